/* hw/cls_pkg.sv */
/* LED scanner shared constants
   Register map, bus and counter widths, and the 18-step frame code cycle */
package cls_pkg;

  // Channel and LED count
  localparam int LED_COUNT   = 10;

  // Frame position encoding
  localparam int POS_W       = 5;
  localparam int FRAME_COUNT = 18;

  // PWM counter and prescaler widths
  localparam int DUTY_W      = 8;
  localparam int PERIOD_W    = 16;

  // Wishbone widths, word addressed
  localparam int WB_ADDR_W   = 4;
  localparam int WB_DATA_W   = 16;

  // Register map, duty levels at 0 to ADDR_DUTY_LAST
  localparam logic [WB_ADDR_W-1:0] ADDR_DUTY_LAST = 4'd9;
  localparam logic [WB_ADDR_W-1:0] ADDR_PERIOD    = 4'd10;
  localparam logic [WB_ADDR_W-1:0] ADDR_CTRL      = 4'd11;
  localparam logic [WB_ADDR_W-1:0] ADDR_STATUS    = 4'd12;

  localparam logic [PERIOD_W-1:0] PERIOD_RESET = 16'd15;

  // Frame codes in cycle order, outward sweep F0..F9 then return F10..F17
  localparam logic [POS_W-1:0] F0  = 5'b00000;
  localparam logic [POS_W-1:0] F1  = 5'b00001;
  localparam logic [POS_W-1:0] F2  = 5'b00011;
  localparam logic [POS_W-1:0] F3  = 5'b00010;
  localparam logic [POS_W-1:0] F4  = 5'b00110;
  localparam logic [POS_W-1:0] F5  = 5'b00111;
  localparam logic [POS_W-1:0] F6  = 5'b00101;
  localparam logic [POS_W-1:0] F7  = 5'b00100;
  localparam logic [POS_W-1:0] F8  = 5'b01100;
  localparam logic [POS_W-1:0] F9  = 5'b11100;
  localparam logic [POS_W-1:0] F10 = 5'b10100;
  localparam logic [POS_W-1:0] F11 = 5'b10101;
  localparam logic [POS_W-1:0] F12 = 5'b10111;
  localparam logic [POS_W-1:0] F13 = 5'b10110;
  localparam logic [POS_W-1:0] F14 = 5'b10010;
  localparam logic [POS_W-1:0] F15 = 5'b10011;
  localparam logic [POS_W-1:0] F16 = 5'b10001;
  localparam logic [POS_W-1:0] F17 = 5'b10000;

  // Same codes as a table, entry i holds frame index i
  localparam logic [FRAME_COUNT-1:0][POS_W-1:0] FRAME_CODE = {
    F17, F16, F15, F14, F13, F12,
    F11, F10, F9,  F8,  F7,  F6,
    F5,  F4,  F3,  F2,  F1,  F0
  };

endpackage

/* hw/cls_wb_regs.sv */
/* Wishbone classic register slave
   Holds the ten duty levels, frame period and run enable; reports frame position */
`timescale 1ns/1ps

module cls_wb_regs (
  input  logic                                              SRT_TICK,
  input  logic                                              PWM_TIMER_TICK,
  input  logic                                              cyc,
  input  logic                                              stb,
  input  logic                                              we,
  input  logic [cls_pkg::WB_ADDR_W-1:0]                     adr,
  input  logic [cls_pkg::WB_DATA_W-1:0]                     dat_w,
  input  logic [cls_pkg::POS_W-1:0]                         frame_pos,
  output logic [cls_pkg::WB_DATA_W-1:0]                     dat_r,
  output logic                                              ack,
  output logic [cls_pkg::LED_COUNT-1:0][cls_pkg::DUTY_W-1:0] duty,
  output logic [cls_pkg::PERIOD_W-1:0]                      frame_period,
  output logic                                              run
);

  logic                          req;
  logic [cls_pkg::WB_DATA_W-1:0] rd_word;

  // New request not yet acknowledged
  assign req = cyc & stb & ~ack;

  // Read decode
  always_comb begin
    rd_word = '0;
    if (adr <= cls_pkg::ADDR_DUTY_LAST) begin
      rd_word[cls_pkg::DUTY_W-1:0] = duty[adr];
    end else begin
      case (adr)
        cls_pkg::ADDR_PERIOD: rd_word[cls_pkg::PERIOD_W-1:0] = frame_period;
        cls_pkg::ADDR_CTRL:   rd_word[0] = run;
        cls_pkg::ADDR_STATUS: rd_word[cls_pkg::POS_W-1:0] = frame_pos;
        default:              rd_word = '0;
      endcase
    end
  end

  // Ack and read data land one cycle after the request
  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      ack   <= 1'b0;
      dat_r <= '0;
    end else begin
      ack <= req;
      if (req && !we) begin
        dat_r <= rd_word;
      end
    end
  end

  // Register writes take effect on the ack edge
  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      duty         <= '0;
      frame_period <= cls_pkg::PERIOD_RESET;
      run          <= 1'b0;
    end else if (req && we) begin
      if (adr <= cls_pkg::ADDR_DUTY_LAST) begin
        duty[adr] <= dat_w[cls_pkg::DUTY_W-1:0];
      end else if (adr == cls_pkg::ADDR_PERIOD) begin
        frame_period <= dat_w[cls_pkg::PERIOD_W-1:0];
      end else if (adr == cls_pkg::ADDR_CTRL) begin
        run <= dat_w[0];
      end
      // Status is read only
    end
  end

  // Ack never stays high for two cycles
  a_ack_single: assert property (
    @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
    ack |=> !ack
  ) else $error("cls_wb_regs: ack high in two consecutive cycles");

endmodule

/* hw/cls_pwm_channel_bank.sv */
/* PWM channel bank
   One shared free-running counter compared against ten duty levels */
`timescale 1ns/1ps

module cls_pwm_channel_bank (
  input  logic                                              SRT_TICK,
  input  logic                                              PWM_TIMER_TICK,
  input  logic [cls_pkg::LED_COUNT-1:0][cls_pkg::DUTY_W-1:0] duty,
  output logic [cls_pkg::LED_COUNT-1:0]                     pwm_channel_sigs
);

  logic [cls_pkg::DUTY_W-1:0]    cnt;
  logic [cls_pkg::LED_COUNT-1:0] cmp;

  // Wraps every 256 cycles
  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // High while the counter is below the level
  always_comb begin
    for (int i = 0; i < cls_pkg::LED_COUNT; i++) begin
      cmp[i] = (cnt < duty[i]);
    end
  end

  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      pwm_channel_sigs <= '0;
    end else begin
      pwm_channel_sigs <= cmp;
    end
  end

  // A zero level keeps its channel dark
  for (genvar g = 0; g < cls_pkg::LED_COUNT; g++) begin : g_zero_chk
    a_zero_dark: assert property (
      @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
      (duty[g] == '0) |=> !pwm_channel_sigs[g]
    ) else $error("cls_pwm_channel_bank: channel %0d high with zero duty", g);
  end

endmodule

/* hw/cls_frame_sequencer.sv */
/* Frame sequencer
   Prescaler strobe steps the frame position through the 18-code cycle */
`timescale 1ns/1ps

module cls_frame_sequencer (
  input  logic                         SRT_TICK,
  input  logic                         PWM_TIMER_TICK,
  input  logic [cls_pkg::PERIOD_W-1:0] frame_period,
  input  logic                         run,
  output logic [cls_pkg::POS_W-1:0]    frame_pos
);

  logic [cls_pkg::PERIOD_W-1:0] presc;
  logic                         adv;
  logic [cls_pkg::POS_W-1:0]    pos_next;
  logic                         pos_legal;

  // Successor of the current code
  always_comb begin
    pos_legal = 1'b1;
    case (frame_pos)
      cls_pkg::F0:  pos_next = cls_pkg::F1;
      cls_pkg::F1:  pos_next = cls_pkg::F2;
      cls_pkg::F2:  pos_next = cls_pkg::F3;
      cls_pkg::F3:  pos_next = cls_pkg::F4;
      cls_pkg::F4:  pos_next = cls_pkg::F5;
      cls_pkg::F5:  pos_next = cls_pkg::F6;
      cls_pkg::F6:  pos_next = cls_pkg::F7;
      cls_pkg::F7:  pos_next = cls_pkg::F8;
      cls_pkg::F8:  pos_next = cls_pkg::F9;
      cls_pkg::F9:  pos_next = cls_pkg::F10;
      cls_pkg::F10: pos_next = cls_pkg::F11;
      cls_pkg::F11: pos_next = cls_pkg::F12;
      cls_pkg::F12: pos_next = cls_pkg::F13;
      cls_pkg::F13: pos_next = cls_pkg::F14;
      cls_pkg::F14: pos_next = cls_pkg::F15;
      cls_pkg::F15: pos_next = cls_pkg::F16;
      cls_pkg::F16: pos_next = cls_pkg::F17;
      cls_pkg::F17: pos_next = cls_pkg::F0;
      default: begin
        pos_next  = cls_pkg::F0;
        pos_legal = 1'b0;
      end
    endcase
  end

  // Prescaler, adv strobes once per frame_period + 1 cycles
  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      presc <= '0;
      adv   <= 1'b0;
    end else if (!run) begin
      presc <= '0;
      adv   <= 1'b0;
    end else if (presc == frame_period) begin
      presc <= '0;
      adv   <= 1'b1;
    end else begin
      presc <= presc + 1'b1;
      adv   <= 1'b0;
    end
  end

  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      frame_pos <= cls_pkg::F0;
    end else if (run && adv) begin
      frame_pos <= pos_next;
    end
  end

  // Successor taken from the package code table
  function automatic logic [cls_pkg::POS_W-1:0] table_succ(
    input logic [cls_pkg::POS_W-1:0] code
  );
    logic [cls_pkg::POS_W-1:0] s;
    s = cls_pkg::F0;
    for (int i = 0; i < cls_pkg::FRAME_COUNT; i++) begin
      if (cls_pkg::FRAME_CODE[i] == code) begin
        s = cls_pkg::FRAME_CODE[(i + 1) % cls_pkg::FRAME_COUNT];
      end
    end
    return s;
  endfunction

  a_pos_legal: assert property (
    @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
    pos_legal
  ) else $error("cls_frame_sequencer: illegal frame code %b", frame_pos);

  a_pos_step: assert property (
    @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
    $changed(frame_pos) |-> (frame_pos == table_succ($past(frame_pos)))
  ) else $error("cls_frame_sequencer: frame step out of sequence");

endmodule

/* hw/cls_led_output_mux.sv */
/* LED output multiplexer
   Routes the ten PWM channels onto the LEDs by frame, one register stage */
`timescale 1ns/1ps

module cls_led_output_mux (
  input  logic                          SRT_TICK,
  input  logic                          PWM_TIMER_TICK,
  input  logic [cls_pkg::POS_W-1:0]     frame_pos,
  input  logic [cls_pkg::LED_COUNT-1:0] pwm_channel_sigs,
  output logic [cls_pkg::LED_COUNT-1:0] ledr
);

  logic [cls_pkg::LED_COUNT-1:0] ledr_next;

  // Frame index of a code, illegal codes map to frame 0
  function automatic int frame_index(input logic [cls_pkg::POS_W-1:0] code);
    int k;
    k = 0;
    for (int i = 0; i < cls_pkg::FRAME_COUNT; i++) begin
      if (cls_pkg::FRAME_CODE[i] == code) begin
        k = i;
      end
    end
    return k;
  endfunction

  // Channel-to-LED routing for one frame
  function automatic logic [cls_pkg::LED_COUNT-1:0] route(
    input logic [cls_pkg::POS_W-1:0]     code,
    input logic [cls_pkg::LED_COUNT-1:0] p
  );
    logic [cls_pkg::LED_COUNT-1:0] r;
    int k;
    int top;
    int back;
    int ch;
    r    = '0;
    k    = frame_index(code);
    top  = cls_pkg::LED_COUNT - 1;
    back = k - top;
    for (int j = 0; j < cls_pkg::LED_COUNT; j++) begin
      if (k <= top) begin
        // Outward sweep, head reversed at the top LEDs
        if (j >= top - k) begin
          ch = 2 * top - k - j;
        end else begin
          ch = j - k;
        end
      end else begin
        // Return sweep, head reversed at the bottom LEDs
        if (j <= back) begin
          ch = top - back + j;
        end else begin
          ch = top - j - back;
        end
      end
      if (ch < 0) begin
        ch = 0;
      end
      r[j] = p[ch];
    end
    return r;
  endfunction

  assign ledr_next = route(frame_pos, pwm_channel_sigs);

  always_ff @(posedge SRT_TICK or posedge PWM_TIMER_TICK) begin
    if (PWM_TIMER_TICK) begin
      ledr <= '0;
    end else begin
      ledr <= ledr_next;
    end
  end

  // Known inputs give known LEDs
  a_ledr_known: assert property (
    @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
    !$isunknown({$past(frame_pos), $past(pwm_channel_sigs)}) |-> !$isunknown(ledr)
  ) else $error("cls_led_output_mux: ledr has unknown bits");

  // One-cycle latency through the routing
  a_ledr_route: assert property (
    @(posedge SRT_TICK) disable iff (PWM_TIMER_TICK)
    ledr == route($past(frame_pos), $past(pwm_channel_sigs))
  ) else $error("cls_led_output_mux: ledr %b does not match routing", ledr);

endmodule

/* hw/cls_led_scanner_top.sv */
/* LED scanner top level
   Register slave, PWM bank, frame sequencer and LED multiplexer */
`timescale 1ns/1ps

module cls_led_scanner_top (
  input  logic                          SRT_TICK,
  input  logic                          PWM_TIMER_TICK,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [cls_pkg::WB_ADDR_W-1:0] adr,
  input  logic [cls_pkg::WB_DATA_W-1:0] dat_w,
  output logic [cls_pkg::WB_DATA_W-1:0] dat_r,
  output logic                          ack,
  output logic [cls_pkg::LED_COUNT-1:0] ledr
);

  logic [cls_pkg::LED_COUNT-1:0][cls_pkg::DUTY_W-1:0] duty;
  logic [cls_pkg::PERIOD_W-1:0]                      frame_period;
  logic                                              run;
  logic [cls_pkg::POS_W-1:0]                         frame_pos;
  logic [cls_pkg::LED_COUNT-1:0]                     pwm_channel_sigs;

  cls_wb_regs wb_regs_i (
    .SRT_TICK       (SRT_TICK),
    .PWM_TIMER_TICK (PWM_TIMER_TICK),
    .cyc            (cyc),
    .stb            (stb),
    .we             (we),
    .adr            (adr),
    .dat_w          (dat_w),
    .frame_pos      (frame_pos),
    .dat_r          (dat_r),
    .ack            (ack),
    .duty           (duty),
    .frame_period   (frame_period),
    .run            (run)
  );

  cls_pwm_channel_bank pwm_bank_i (
    .SRT_TICK         (SRT_TICK),
    .PWM_TIMER_TICK   (PWM_TIMER_TICK),
    .duty             (duty),
    .pwm_channel_sigs (pwm_channel_sigs)
  );

  cls_frame_sequencer frame_seq_i (
    .SRT_TICK       (SRT_TICK),
    .PWM_TIMER_TICK (PWM_TIMER_TICK),
    .frame_period   (frame_period),
    .run            (run),
    .frame_pos      (frame_pos)
  );

  cls_led_output_mux led_mux_i (
    .SRT_TICK         (SRT_TICK),
    .PWM_TIMER_TICK   (PWM_TIMER_TICK),
    .frame_pos        (frame_pos),
    .pwm_channel_sigs (pwm_channel_sigs),
    .ledr             (ledr)
  );

endmodule

/* sim/cls_tb_util.svh */
/* LED scanner testbench helpers
   LFSR source, Wishbone master tasks and reference frame routing */
`ifndef CLS_TB_UTIL_SVH
`define CLS_TB_UTIL_SVH

// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
function automatic logic [31:0] get_rand(input int nbits);
  logic [31:0] value;
  logic fb;
  value = '0;
  for (int i = 0; i < nbits; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    value = {value[30:0], fb};
  end
  return value;
endfunction

task automatic wb_write(input logic [3:0] a, input logic [15:0] d);
  @(negedge clk);
  cyc = 1'b1;
  stb = 1'b1;
  we = 1'b1;
  adr = a;
  dat_w = d;
  do @(negedge clk); while (!ack);
  cyc = 1'b0;
  stb = 1'b0;
  we = 1'b0;
endtask

task automatic wb_read(input logic [3:0] a, output logic [15:0] d);
  @(negedge clk);
  cyc = 1'b1;
  stb = 1'b1;
  we = 1'b0;
  adr = a;
  do @(negedge clk); while (!ack);
  d = dat_r;
  cyc = 1'b0;
  stb = 1'b0;
endtask

// Codes of the 18-frame cycle
function automatic logic [4:0] code_of(input int k);
  case (k)
    0: return 5'b00000;
    1: return 5'b00001;
    2: return 5'b00011;
    3: return 5'b00010;
    4: return 5'b00110;
    5: return 5'b00111;
    6: return 5'b00101;
    7: return 5'b00100;
    8: return 5'b01100;
    9: return 5'b11100;
    10: return 5'b10100;
    11: return 5'b10101;
    12: return 5'b10111;
    13: return 5'b10110;
    14: return 5'b10010;
    15: return 5'b10011;
    16: return 5'b10001;
    default: return 5'b10000;
  endcase
endfunction

function automatic int index_of(input logic [4:0] code);
  int k;
  k = -1;
  for (int i = 0; i < 18; i++) begin
    if (code_of(i) == code) k = i;
  end
  return k;
endfunction

function automatic logic [4:0] next_code(input logic [4:0] code);
  return code_of((index_of(code) + 1) % 18);
endfunction

// Forward frames put the reversed head on the top LEDs and return frames on the bottom
function automatic logic [9:0] ref_route(input logic [4:0] code, input logic [9:0] p);
  logic [9:0] r;
  int k;
  int ch;
  k = index_of(code);
  if (k < 0) k = 0;
  for (int led = 0; led < 10; led++) begin
    if (k <= 9) begin
      ch = (led >= 9 - k) ? (9 - k + (9 - led)) : (led - k);
    end else begin
      ch = (led <= k - 9) ? (9 - (k - 9) + led) : (9 - led - (k - 9));
    end
    r[led] = p[(ch < 0) ? 0 : ch];
  end
  return r;
endfunction

`endif

/* sim/cls_led_scanner_tb.sv */
/* LED scanner testbench
   Drives the Wishbone port and checks PWM, frame stepping and LED routing */
`timescale 1ns/1ps

module cls_led_scanner_tb;

  localparam int CLK_NS = 8;
  // Watchdog allows twice the summed cycle budget of the tests
  localparam int CYC_PWM = 400;
  localparam int CYC_REGS = 300;
  localparam int CYC_STEP = 18 * 6 + 300;
  localparam int CYC_ROUTE = 2 * 18 * 40 + 200;
  localparam int CYC_HOLD = 12 * 40 + 300;
  localparam int WATCHDOG_NS = 2 * CLK_NS * (CYC_PWM + CYC_REGS + CYC_STEP + CYC_ROUTE + CYC_HOLD);

  logic clk;
  logic rst;
  logic cyc;
  logic stb;
  logic we;
  logic [3:0] adr;
  logic [15:0] dat_w;
  logic [15:0] dat_r;
  logic ack;
  logic [9:0] ledr;

  logic [31:0] lfsr_state = 32'h7743;
  logic [7:0] duty_set [10];
  int cur_period;
  logic [9:0] exp_ledr;
  logic [4:0] prev_pos;
  int gap_cnt;
  logic have_gap;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      fail_run("value check failed");
    end
  endtask

  `include "cls_tb_util.svh"

  cls_led_scanner_top dut_i (
    .SRT_TICK       (clk),
    .PWM_TIMER_TICK (rst),
    .cyc            (cyc),
    .stb            (stb),
    .we             (we),
    .adr            (adr),
    .dat_w          (dat_w),
    .dat_r          (dat_r),
    .ack            (ack),
    .ledr           (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests completed");
  end

  // Expected LEDs from the inputs as they stood at the previous edge
  always @(posedge clk or posedge rst) begin
    if (rst) exp_ledr <= '0;
    else exp_ledr <= ref_route(dut_i.frame_pos, dut_i.pwm_channel_sigs);
  end

  a_route: assert property (@(posedge clk) disable iff (rst) ledr == exp_ledr)
    else begin
      $display("mismatch at %0t: ledr got %b expected %b", $time, $sampled(ledr),
               $sampled(exp_ledr));
      fail_run("LED routing check failed");
    end

  a_ack_next: assert property (@(posedge clk) disable iff (rst) (cyc && stb && !ack) |=> ack)
    else fail_run("Wishbone request was not acknowledged in the next cycle");

  a_ack_once: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else fail_run("Wishbone ack stayed high for two cycles");

  // Frame step order and spacing
  always @(negedge clk) begin
    if (rst || !dut_i.run) begin
      have_gap <= 1'b0;
      gap_cnt <= 0;
      prev_pos <= dut_i.frame_pos;
    end else if (dut_i.frame_pos != prev_pos) begin
      check_eq("frame_pos", dut_i.frame_pos, next_code(prev_pos));
      if (have_gap) check_eq("frame gap", gap_cnt + 1, cur_period + 1);
      have_gap <= 1'b1;
      gap_cnt <= 0;
      prev_pos <= dut_i.frame_pos;
    end else begin
      gap_cnt <= gap_cnt + 1;
    end
  end

  initial begin
    logic [15:0] rd;
    logic [31:0] rnd;
    int hi_cnt [10];
    int seen;
    logic [4:0] held;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    cur_period = 15;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // Reset state
    @(negedge clk);
    check_eq("ledr", ledr, 0);
    check_eq("ack", ack, 0);
    wb_read(cls_pkg::ADDR_STATUS, rd);
    check_eq("status", rd, code_of(0));

    // PWM duty at frame F0 where routing is the identity
    for (int i = 0; i < 10; i++) begin
      rnd = get_rand(8);
      duty_set[i] = (i == 0) ? 8'd0 : (i == 1) ? 8'd255 : rnd[7:0];
      wb_write(4'(i), {8'h00, duty_set[i]});
    end
    repeat (4) @(negedge clk);
    for (int i = 0; i < 10; i++) hi_cnt[i] = 0;
    repeat (256) begin
      @(negedge clk);
      for (int i = 0; i < 10; i++) hi_cnt[i] += ledr[i];
    end
    for (int i = 0; i < 10; i++) check_eq($sformatf("ledr[%0d] high cycles", i), hi_cnt[i],
                                          duty_set[i]);

    // Register access
    for (int i = 0; i < 10; i++) begin
      wb_read(4'(i), rd);
      check_eq($sformatf("duty[%0d]", i), rd, duty_set[i]);
    end
    wb_read(cls_pkg::ADDR_PERIOD, rd);
    check_eq("period", rd, 15);
    wb_write(cls_pkg::ADDR_PERIOD, 16'h1234);
    wb_read(cls_pkg::ADDR_PERIOD, rd);
    check_eq("period", rd, 16'h1234);
    wb_write(cls_pkg::ADDR_CTRL, 16'h0001);
    wb_read(cls_pkg::ADDR_CTRL, rd);
    check_eq("ctrl", rd, 1);
    wb_write(cls_pkg::ADDR_CTRL, 16'h0000);
    wb_read(cls_pkg::ADDR_CTRL, rd);
    check_eq("ctrl", rd, 0);
    wb_write(cls_pkg::ADDR_STATUS, 16'h001f);
    wb_read(cls_pkg::ADDR_STATUS, rd);
    check_eq("status", rd, code_of(0));
    for (int a = 13; a < 16; a++) begin
      wb_read(4'(a), rd);
      check_eq($sformatf("unused addr %0d", a), rd, 0);
    end

    // Frame stepping with a short period
    cur_period = 5;
    wb_write(cls_pkg::ADDR_PERIOD, 16'(cur_period));
    wb_write(cls_pkg::ADDR_CTRL, 16'h0001);
    held = code_of(0);
    seen = 0;
    while (seen < 18) begin
      wb_read(cls_pkg::ADDR_STATUS, rd);
      if (rd[4:0] != held) begin
        check_eq("status step", rd[4:0], next_code(held));
        held = rd[4:0];
        seen++;
      end
    end
    wb_write(cls_pkg::ADDR_CTRL, 16'h0000);

    // Routing over full cycles with random duty patterns
    cur_period = 39;
    wb_write(cls_pkg::ADDR_PERIOD, 16'(cur_period));
    for (int pat = 0; pat < 2; pat++) begin
      for (int i = 0; i < 10; i++) begin
        rnd = get_rand(8);
        wb_write(4'(i), rnd[15:0] & 16'h00ff);
      end
      wb_write(cls_pkg::ADDR_CTRL, 16'h0001);
      repeat (18 * (cur_period + 1) + 4) @(negedge clk);
      wb_write(cls_pkg::ADDR_CTRL, 16'h0000);
    end

    // Hold and resume
    wb_write(cls_pkg::ADDR_CTRL, 16'h0001);
    repeat (3 * (cur_period + 1)) @(negedge clk);
    wb_write(cls_pkg::ADDR_CTRL, 16'h0000);
    wb_read(cls_pkg::ADDR_STATUS, rd);
    held = rd[4:0];
    repeat (5 * (cur_period + 1)) @(negedge clk);
    wb_read(cls_pkg::ADDR_STATUS, rd);
    check_eq("held status", rd[4:0], held);
    wb_write(cls_pkg::ADDR_CTRL, 16'h0001);
    do wb_read(cls_pkg::ADDR_STATUS, rd); while (rd[4:0] == held);
    check_eq("resumed status", rd[4:0], next_code(held));

    repeat (4) @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* cls_led_scanner.f */
+incdir+sim
hw/cls_pkg.sv
hw/cls_wb_regs.sv
hw/cls_pwm_channel_bank.sv
hw/cls_frame_sequencer.sv
hw/cls_led_output_mux.sv
hw/cls_led_scanner_top.sv
sim/cls_led_scanner_tb.sv

/* Makefile */
# Verilator build and run for the LED scanner subsystem

VERILATOR   ?= verilator
TOP         ?= cls_led_scanner_tb
RTL_TOP     ?= cls_led_scanner_top
FILELIST    ?= cls_led_scanner.f
BUILD_DIR   ?= obj_dir
PASS_TEXT   ?= Result: PASSED
VFLAGS      ?= --binary --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) hw/cls_pkg.sv hw/cls_wb_regs.sv \
		hw/cls_pwm_channel_bank.sv hw/cls_frame_sequencer.sv \
		hw/cls_led_output_mux.sv hw/cls_led_scanner_top.sv

clean:
	rm -rf $(BUILD_DIR)
